/* files.f */
+incdir+verif
rtl/gmii_udp_pkg.sv
rtl/line_gate.sv
rtl/frame_sequencer.sv
rtl/header_builder.sv
rtl/fcs_unit.sv
rtl/gmii_udp_tx.sv
verif/gmii_udp_tx_tb.sv

/* Bender.yml */
package:
  name: gmii_udp_tx

sources:
  - files:
      - rtl/gmii_udp_pkg.sv
      - rtl/line_gate.sv
      - rtl/frame_sequencer.sv
      - rtl/header_builder.sv
      - rtl/fcs_unit.sv
      - rtl/gmii_udp_tx.sv
  - target: test
    include_dirs:
      - verif
    files:
      - verif/gmii_udp_tx_tb.sv

/* verif/frame_model.svh */
`ifndef FRAME_MODEL_SVH
`define FRAME_MODEL_SVH

typedef gmii_udp_pkg::byte_t       byte_q_t[$];
typedef gmii_udp_pkg::pixel_word_t word_q_t[$];

// One's-complement sum over the 20 header bytes starting at base
function automatic gmii_udp_pkg::csum_t ip_checksum(byte_q_t q, int base);
	int unsigned sum;
	sum = 0;
	for (int i = 0; i < 20; i += 2)
		sum += {q[base + i], q[base + i + 1]};
	while (sum > 32'hFFFF)
		sum = (sum & 32'hFFFF) + (sum >> 16);
	return ~gmii_udp_pkg::csum_t'(sum);
endfunction

// Bitwise Ethernet CRC-32, inverted result
function automatic gmii_udp_pkg::crc_t frame_crc(byte_q_t q, int first, int last);
	logic [31:0] crc;
	crc = '1;
	for (int i = first; i <= last; i++) begin
		crc ^= {24'd0, q[i]};
		for (int b = 0; b < 8; b++)
			crc = crc[0] ? ((crc >> 1) ^ 32'hEDB8_8320) : (crc >> 1);
	end
	return ~crc;
endfunction

// Expected wire bytes of one frame, preamble through FCS
function automatic byte_q_t build_frame(gmii_udp_pkg::station_id_t id, word_q_t words);
	byte_q_t             q;
	logic [47:0]         dmac;
	logic [47:0]         smac;
	logic [31:0]         sip;
	logic [31:0]         dip;
	logic [15:0]         ip_w[4];
	logic [15:0]         udp_w[4];
	gmii_udp_pkg::csum_t cs;
	gmii_udp_pkg::crc_t  fcs;
	int                  ip_base;
	dmac = gmii_udp_pkg::DST_MAC;
	smac = gmii_udp_pkg::SRC_MAC;
	smac[7:0] = smac[7:0] + 8'(id);
	sip = gmii_udp_pkg::SRC_IP;
	sip[7:0] = sip[7:0] + 8'(id);
	dip = gmii_udp_pkg::DST_IP;
	ip_w = '{gmii_udp_pkg::IP_VER_TOS, gmii_udp_pkg::IP_LEN, gmii_udp_pkg::IP_IDENT,
		gmii_udp_pkg::IP_FLAGS};
	udp_w = '{gmii_udp_pkg::UDP_SRC_PORT, gmii_udp_pkg::UDP_DST_PORT,
		gmii_udp_pkg::UDP_LEN, 16'h0000};
	repeat (7) q.push_back(8'h55);
	q.push_back(8'hD5);
	for (int i = 5; i >= 0; i--) q.push_back(dmac[8 * i +: 8]);
	for (int i = 5; i >= 0; i--) q.push_back(smac[8 * i +: 8]);
	q.push_back(gmii_udp_pkg::ETH_TYPE[15:8]);
	q.push_back(gmii_udp_pkg::ETH_TYPE[7:0]);
	// IPv4 header with checksum zero, patched afterwards
	ip_base = q.size();
	foreach (ip_w[i]) begin
		q.push_back(ip_w[i][15:8]);
		q.push_back(ip_w[i][7:0]);
	end
	q.push_back(gmii_udp_pkg::IP_TTL);
	q.push_back(gmii_udp_pkg::IP_PROTO);
	q.push_back(8'h00);
	q.push_back(8'h00);
	for (int i = 3; i >= 0; i--) q.push_back(sip[8 * i +: 8]);
	for (int i = 3; i >= 0; i--) q.push_back(dip[8 * i +: 8]);
	cs = ip_checksum(q, ip_base);
	q[ip_base + 10] = cs[15:8];
	q[ip_base + 11] = cs[7:0];
	foreach (udp_w[i]) begin
		q.push_back(udp_w[i][15:8]);
		q.push_back(udp_w[i][7:0]);
	end
	// Line number word, then pixel words, high byte first
	foreach (words[i]) begin
		q.push_back(words[i][15:8]);
		q.push_back(words[i][7:0]);
	end
	fcs = frame_crc(q, 8, q.size() - 1);
	for (int i = 0; i < 4; i++) q.push_back(fcs[8 * i +: 8]);
	return q;
endfunction

`endif

/* verif/gmii_udp_tx_tb.sv */
`timescale 1ns/10ps

module gmii_udp_tx_tb;

	`include "frame_model.svh"

	localparam int TIMEOUT_CYCLES = 20 * (120 + gmii_udp_pkg::GAP_CYCLES +
		gmii_udp_pkg::WORDS_PER_LINE + 20) + 200;

	logic                      fifo_clk;
	logic                      sys_rst;
	gmii_udp_pkg::station_id_t id;
	gmii_udp_pkg::pixel_word_t dout = '0;
	logic                      empty = 1'b1;
	logic                      wr_en;
	logic                      rd_en;
	logic                      line_pending;
	logic                      tx_en;
	gmii_udp_pkg::byte_t       txd;

	gmii_udp_pkg::pixel_word_t wr_data = '0;
	gmii_udp_pkg::pixel_word_t fifo_q[$];
	gmii_udp_pkg::pixel_word_t exp_words[$];
	gmii_udp_pkg::station_id_t exp_id[$];
	gmii_udp_pkg::station_id_t id_val;
	gmii_udp_pkg::pixel_word_t line_no = '0;
	byte_q_t                   rx_bytes;
	int                        frames_rcvd = 0;
	int                        frames_started = 0;
	int                        pops = 0;
	int                        low_cnt = 0;
	int                        cycle_cnt = 0;
	logic                      tx_en_q = 1'b0;

	gmii_udp_tx u_dut (
		.fifo_clk     (fifo_clk),
		.sys_rst      (sys_rst),
		.id           (id),
		.dout         (dout),
		.empty        (empty),
		.wr_en        (wr_en),
		.rd_en        (rd_en),
		.line_pending (line_pending),
		.tx_en        (tx_en),
		.txd          (txd)
	);

	initial begin
		fifo_clk = 1'b0;
		forever #10 fifo_clk = ~fifo_clk;
	end

	// ------------------------------------------------------------
	// Failure reporting and compare tasks
	// ------------------------------------------------------------
	task automatic abort_run(string msg);
		$display("%s", msg);
		$display("Simulation finished: FAIL");
		$fatal(1, "run aborted");
	endtask

	task automatic check_byte(string name, gmii_udp_pkg::byte_t exp, gmii_udp_pkg::byte_t act);
		if (act !== exp)
			abort_run($sformatf("FAILED %s: expected 0x%02h, actual 0x%02h", name, exp, act));
	endtask

	task automatic check_flag(string name, logic exp, logic act);
		if (act !== exp)
			abort_run($sformatf("FAILED %s: expected %b, actual %b", name, exp, act));
	endtask

	task automatic check_count(string name, gmii_udp_pkg::line_count_t exp,
		gmii_udp_pkg::line_count_t act);
		if (act !== exp)
			abort_run($sformatf("FAILED %s: expected %0d, actual %0d", name, exp, act));
	endtask

	task automatic check_gap(string name, int act);
		if (act < gmii_udp_pkg::GAP_CYCLES)
			abort_run($sformatf("FAILED %s: expected >= %0d, actual %0d", name,
				gmii_udp_pkg::GAP_CYCLES, act));
	endtask

	task automatic check_words(string name, int exp, int act);
		if (act != exp)
			abort_run($sformatf("FAILED %s: expected %0d, actual %0d", name, exp, act));
	endtask

	task automatic check_length(string name, int exp, int act);
		if (act != exp)
			abort_run($sformatf("FAILED %s: expected %0d, actual %0d", name, exp, act));
	endtask

	// ------------------------------------------------------------
	// FWFT FIFO model that pops on rd_en in the same cycle
	// ------------------------------------------------------------
	always @(posedge fifo_clk) begin
		if (sys_rst) begin
			fifo_q.delete();
		end else begin
			if (rd_en) begin
				if (fifo_q.size() == 0)
					abort_run("rd_en was raised while the FIFO was empty");
				else
					void'(fifo_q.pop_front());
			end
			if (wr_en)
				fifo_q.push_back(wr_data);
		end
		empty <= (fifo_q.size() == 0);
		dout  <= (fifo_q.size() != 0) ? fifo_q[0] : '0;
	end

	// Compare one received burst with the model
	task automatic compare_frame();
		word_q_t                   words;
		byte_q_t                   expected;
		gmii_udp_pkg::station_id_t fid;
		string                     field;
		if (exp_id.size() == 0)
			abort_run("a frame was sent without a completed line");
		fid = exp_id.pop_front();
		for (int i = 0; i < gmii_udp_pkg::WORDS_PER_LINE; i++)
			words.push_back(exp_words.pop_front());
		expected = build_frame(fid, words);
		check_length($sformatf("frame %0d length", frames_rcvd), expected.size(),
			rx_bytes.size());
		foreach (expected[i]) begin
			field = (i >= expected.size() - 4) ? "fcs" : "data";
			check_byte($sformatf("frame %0d %s byte %0d", frames_rcvd, field, i),
				expected[i], rx_bytes[i]);
		end
		check_words($sformatf("frame %0d reads", frames_rcvd),
			gmii_udp_pkg::WORDS_PER_LINE, pops);
		pops = 0;
		rx_bytes.delete();
		frames_rcvd++;
	endtask

	// GMII monitor
	always @(posedge fifo_clk) begin
		if (!sys_rst) begin
			if (rd_en)
				pops++;
			if (tx_en) begin
				if (!tx_en_q) begin
					frames_started++;
					if (frames_rcvd > 0)
						check_gap($sformatf("gap before frame %0d", frames_rcvd), low_cnt);
				end
				rx_bytes.push_back(txd);
				low_cnt = 0;
			end else begin
				if (tx_en_q)
					compare_frame();
				low_cnt++;
			end
			tx_en_q = tx_en;
		end
	end

	always @(posedge fifo_clk) begin
		cycle_cnt++;
		if (cycle_cnt >= TIMEOUT_CYCLES)
			abort_run($sformatf("Timeout, run did not end within %0d cycles", cycle_cnt));
	end

	// ------------------------------------------------------------
	// Stimulus
	// ------------------------------------------------------------
	task automatic write_line();
		gmii_udp_pkg::pixel_word_t w;
		exp_id.push_back(id_val);
		for (int i = 0; i < gmii_udp_pkg::WORDS_PER_LINE; i++) begin
			w = (i == 0) ? line_no : gmii_udp_pkg::pixel_word_t'($urandom);
			exp_words.push_back(w);
			@(posedge fifo_clk);
			wr_en   <= 1'b1;
			wr_data <= w;
		end
		@(posedge fifo_clk);
		wr_en <= 1'b0;
		line_no++;
	endtask

	// New id while idle and then n lines back to back
	task automatic run_lines(int n);
		int start;
		int started;
		start = frames_rcvd;
		while (line_pending)
			@(posedge fifo_clk);
		started = frames_started;
		id_val = gmii_udp_pkg::station_id_t'($urandom);
		@(posedge fifo_clk);
		id <= id_val;
		repeat (n) write_line();
		// Count rises the cycle after wr_en falls
		repeat (2) @(posedge fifo_clk);
		check_flag("line pending after write", 1'b1, line_pending);
		while (frames_rcvd < start + n)
			@(posedge fifo_clk);
		repeat (gmii_udp_pkg::GAP_CYCLES + 4) @(posedge fifo_clk);
		check_count("frames per burst", gmii_udp_pkg::line_count_t'(n),
			gmii_udp_pkg::line_count_t'(frames_started - started));
	endtask

	task automatic watch_idle(int cycles);
		repeat (cycles) begin
			@(posedge fifo_clk);
			if (tx_en || rd_en || line_pending)
				abort_run("Outputs became active after reset with no line written");
		end
		check_byte("txd after reset", 8'h00, txd);
	endtask

	initial begin
		void'($urandom(51));
		sys_rst = 1'b1;
		wr_en   = 1'b0;
		id      = '0;
		id_val  = '0;
		repeat (2) @(posedge fifo_clk);
		sys_rst <= 1'b0;
		watch_idle(50);
		repeat (12) run_lines(1);
		run_lines(3);
		run_lines(2);
		run_lines(3);
		// Late extra frames would still show up here
		repeat (200) @(posedge fifo_clk);
		if (exp_id.size() != 0 || tx_en)
			abort_run("Lines were left unsent at the end of the run");
		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

/* rtl/gmii_udp_tx.sv */
`timescale 1ns/10ps

module gmii_udp_tx (
	input  logic                      fifo_clk,
	input  logic                      sys_rst,
	input  gmii_udp_pkg::station_id_t id,
	input  gmii_udp_pkg::pixel_word_t dout,
	input  logic                      empty,
	input  logic                      wr_en,
	output logic                      rd_en,
	output logic                      line_pending,
	output logic                      tx_en,
	output gmii_udp_pkg::byte_t       txd
);

	logic                     frame_start;
	logic                     seq_idle;
	gmii_udp_pkg::tx_state_e  hdr_sel;
	gmii_udp_pkg::field_idx_t hdr_idx;
	gmii_udp_pkg::byte_t      hdr_byte;
	gmii_udp_pkg::tx_item_t   item;

	// Line accounting and frame start decision
	line_gate u_line_gate (
		.fifo_clk     (fifo_clk),
		.sys_rst      (sys_rst),
		.wr_en        (wr_en),
		.empty        (empty),
		.seq_idle     (seq_idle),
		.frame_start  (frame_start),
		.line_pending (line_pending)
	);

	frame_sequencer u_frame_sequencer (
		.fifo_clk    (fifo_clk),
		.sys_rst     (sys_rst),
		.frame_start (frame_start),
		.dout        (dout),
		.hdr_byte    (hdr_byte),
		.seq_idle    (seq_idle),
		.rd_en       (rd_en),
		.hdr_sel     (hdr_sel),
		.hdr_idx     (hdr_idx),
		.item        (item)
	);

	header_builder u_header_builder (
		.fifo_clk    (fifo_clk),
		.sys_rst     (sys_rst),
		.frame_start (frame_start),
		.id          (id),
		.hdr_sel     (hdr_sel),
		.hdr_idx     (hdr_idx),
		.hdr_byte    (hdr_byte)
	);

	// CRC and GMII output registers
	fcs_unit u_fcs_unit (
		.fifo_clk (fifo_clk),
		.sys_rst  (sys_rst),
		.item     (item),
		.tx_en    (tx_en),
		.txd      (txd)
	);

endmodule

/* rtl/fcs_unit.sv */
`timescale 1ns/10ps

module fcs_unit (
	input  logic                   fifo_clk,
	input  logic                   sys_rst,
	input  gmii_udp_pkg::tx_item_t item,
	output logic                   tx_en,
	output gmii_udp_pkg::byte_t    txd
);

	gmii_udp_pkg::crc_t  crc_q;
	gmii_udp_pkg::crc_t  fcs_val;
	gmii_udp_pkg::byte_t fcs_byte;

	// ------------------------------------------------------------
	// CRC-32 over destination MAC through last payload byte
	// ------------------------------------------------------------
	always_ff @(posedge fifo_clk) begin
		if (sys_rst)
			crc_q <= '1;
		else if (item.crc_init)
			crc_q <= '1;
		else if (item.crc_en)
			crc_q <= gmii_udp_pkg::crc32_byte(crc_q, item.data);
	end

	// Reflected register, so bits 7:0 carry x^31..x^24 and go out first
	assign fcs_val  = ~crc_q;
	assign fcs_byte = fcs_val[8 * int'(item.fcs_idx) +: 8];

	// GMII output stage
	always_ff @(posedge fifo_clk) begin
		if (sys_rst) begin
			tx_en <= 1'b0;
			txd   <= '0;
		end else begin
			tx_en <= item.valid;
			txd   <= item.fcs ? fcs_byte : item.data;
		end
	end

endmodule

/* rtl/header_builder.sv */
`timescale 1ns/10ps

module header_builder (
	input  logic                      fifo_clk,
	input  logic                      sys_rst,
	input  logic                      frame_start,
	input  gmii_udp_pkg::station_id_t id,
	input  gmii_udp_pkg::tx_state_e   hdr_sel,
	input  gmii_udp_pkg::field_idx_t  hdr_idx,
	output gmii_udp_pkg::byte_t       hdr_byte
);

	gmii_udp_pkg::station_id_t id_q;
	gmii_udp_pkg::csum_t       csum_q;
	logic                      csum_load;
	logic [47:0]               src_mac_id;
	logic [31:0]               src_ip_id;
	logic [19:0]               csum_sum;
	logic [16:0]               csum_fold;

	gmii_udp_pkg::byte_t [gmii_udp_pkg::ETH_HDR_BYTES-1:0] eth_vec;
	gmii_udp_pkg::byte_t [gmii_udp_pkg::IP_HDR_BYTES-1:0]  ip_vec;
	gmii_udp_pkg::byte_t [gmii_udp_pkg::UDP_HDR_BYTES-1:0] udp_vec;

	// Station id offsets the low address bytes
	assign src_mac_id = {gmii_udp_pkg::SRC_MAC[47:8],
		gmii_udp_pkg::SRC_MAC[7:0] + gmii_udp_pkg::byte_t'(id_q)};
	assign src_ip_id  = {gmii_udp_pkg::SRC_IP[31:8],
		gmii_udp_pkg::SRC_IP[7:0] + gmii_udp_pkg::byte_t'(id_q)};

	// ------------------------------------------------------------
	// IPv4 header checksum, one cycle after the id is captured
	// ------------------------------------------------------------
	assign csum_sum = 20'(gmii_udp_pkg::IP_VER_TOS) + 20'(gmii_udp_pkg::IP_LEN) +
		20'(gmii_udp_pkg::IP_IDENT) + 20'(gmii_udp_pkg::IP_FLAGS) +
		20'({gmii_udp_pkg::IP_TTL, gmii_udp_pkg::IP_PROTO}) +
		20'(src_ip_id[31:16]) + 20'(src_ip_id[15:0]) +
		20'(gmii_udp_pkg::DST_IP[31:16]) + 20'(gmii_udp_pkg::DST_IP[15:0]);
	// End-around carry, second fold cannot overflow again
	assign csum_fold = {1'b0, csum_sum[15:0]} + {13'd0, csum_sum[19:16]};

	always_ff @(posedge fifo_clk) begin
		if (sys_rst)
			csum_load <= 1'b0;
		else
			csum_load <= frame_start;
	end

	always_ff @(posedge fifo_clk) begin
		if (frame_start)
			id_q <= id;
		if (csum_load)
			csum_q <= ~(csum_fold[15:0] + {15'd0, csum_fold[16]});
	end

	// Byte 0 of each field sits in the top element
	assign eth_vec = {gmii_udp_pkg::DST_MAC, src_mac_id, gmii_udp_pkg::ETH_TYPE};
	assign ip_vec  = {gmii_udp_pkg::IP_VER_TOS, gmii_udp_pkg::IP_LEN,
		gmii_udp_pkg::IP_IDENT, gmii_udp_pkg::IP_FLAGS, gmii_udp_pkg::IP_TTL,
		gmii_udp_pkg::IP_PROTO, csum_q, src_ip_id, gmii_udp_pkg::DST_IP};
	// UDP checksum left at zero
	assign udp_vec = {gmii_udp_pkg::UDP_SRC_PORT, gmii_udp_pkg::UDP_DST_PORT,
		gmii_udp_pkg::UDP_LEN, 16'h0000};

	always_comb begin
		case (hdr_sel)
			gmii_udp_pkg::ST_ETH_HDR:
				hdr_byte = eth_vec[gmii_udp_pkg::ETH_HDR_BYTES - 1 - int'(hdr_idx)];
			gmii_udp_pkg::ST_IP_HDR:
				hdr_byte = ip_vec[gmii_udp_pkg::IP_HDR_BYTES - 1 - int'(hdr_idx)];
			gmii_udp_pkg::ST_UDP_HDR:
				hdr_byte = udp_vec[gmii_udp_pkg::UDP_HDR_BYTES - 1 - int'(hdr_idx)];
			default:
				hdr_byte = '0;
		endcase
	end

endmodule

/* rtl/frame_sequencer.sv */
`timescale 1ns/10ps

module frame_sequencer (
	input  logic                      fifo_clk,
	input  logic                      sys_rst,
	input  logic                      frame_start,
	input  gmii_udp_pkg::pixel_word_t dout,
	input  gmii_udp_pkg::byte_t       hdr_byte,
	output logic                      seq_idle,
	output logic                      rd_en,
	output gmii_udp_pkg::tx_state_e   hdr_sel,
	output gmii_udp_pkg::field_idx_t  hdr_idx,
	output gmii_udp_pkg::tx_item_t    item
);

	gmii_udp_pkg::tx_state_e state;
	gmii_udp_pkg::tx_state_e state_next;
	gmii_udp_pkg::tx_item_t  item_d;
	logic [15:0]             byte_cnt;
	logic [15:0]             field_len;
	logic                    field_last;
	logic                    half;

	// State names the field whose byte is chosen this cycle
	assign seq_idle = (state == gmii_udp_pkg::ST_IDLE);
	assign hdr_sel  = state;
	assign hdr_idx  = gmii_udp_pkg::field_idx_t'(byte_cnt);

	// Low byte of a FIFO word on odd counts, fields start word aligned
	assign half  = byte_cnt[0];
	assign rd_en = half && (state == gmii_udp_pkg::ST_LINE_NUM ||
		state == gmii_udp_pkg::ST_PIXELS);

	// ------------------------------------------------------------
	// Field lengths and order
	// ------------------------------------------------------------
	always_comb begin
		case (state)
			gmii_udp_pkg::ST_PREAMBLE: field_len = 16'(gmii_udp_pkg::PREAMBLE_BYTES);
			gmii_udp_pkg::ST_ETH_HDR:  field_len = 16'(gmii_udp_pkg::ETH_HDR_BYTES);
			gmii_udp_pkg::ST_IP_HDR:   field_len = 16'(gmii_udp_pkg::IP_HDR_BYTES);
			gmii_udp_pkg::ST_UDP_HDR:  field_len = 16'(gmii_udp_pkg::UDP_HDR_BYTES);
			gmii_udp_pkg::ST_LINE_NUM: field_len = 16'(gmii_udp_pkg::LINE_NUM_BYTES);
			gmii_udp_pkg::ST_PIXELS:   field_len = 16'(gmii_udp_pkg::PIXEL_BYTES);
			gmii_udp_pkg::ST_FCS:      field_len = 16'(gmii_udp_pkg::FCS_BYTES);
			gmii_udp_pkg::ST_GAP:      field_len = 16'(gmii_udp_pkg::GAP_CYCLES);
			default:                   field_len = 16'd1;
		endcase
	end

	assign field_last = (byte_cnt == field_len - 16'd1);

	always_comb begin
		case (state)
			gmii_udp_pkg::ST_PREAMBLE: state_next = gmii_udp_pkg::ST_SFD;
			gmii_udp_pkg::ST_SFD:      state_next = gmii_udp_pkg::ST_ETH_HDR;
			gmii_udp_pkg::ST_ETH_HDR:  state_next = gmii_udp_pkg::ST_IP_HDR;
			gmii_udp_pkg::ST_IP_HDR:   state_next = gmii_udp_pkg::ST_UDP_HDR;
			gmii_udp_pkg::ST_UDP_HDR:  state_next = gmii_udp_pkg::ST_LINE_NUM;
			gmii_udp_pkg::ST_LINE_NUM: state_next = gmii_udp_pkg::ST_PIXELS;
			gmii_udp_pkg::ST_PIXELS:   state_next = gmii_udp_pkg::ST_FCS;
			gmii_udp_pkg::ST_FCS:      state_next = gmii_udp_pkg::ST_GAP;
			default:                   state_next = gmii_udp_pkg::ST_IDLE;
		endcase
	end

	// ------------------------------------------------------------
	// Byte selection
	// ------------------------------------------------------------
	always_comb begin
		item_d = '0;
		case (state)
			gmii_udp_pkg::ST_IDLE: begin
				// First preamble byte leaves with the start decision
				if (frame_start) begin
					item_d.data  = gmii_udp_pkg::PREAMBLE_BYTE;
					item_d.valid = 1'b1;
				end
			end
			gmii_udp_pkg::ST_PREAMBLE: begin
				item_d.data  = gmii_udp_pkg::PREAMBLE_BYTE;
				item_d.valid = 1'b1;
			end
			gmii_udp_pkg::ST_SFD: begin
				item_d.data     = gmii_udp_pkg::SFD_BYTE;
				item_d.valid    = 1'b1;
				item_d.crc_init = 1'b1;
			end
			gmii_udp_pkg::ST_ETH_HDR, gmii_udp_pkg::ST_IP_HDR,
			gmii_udp_pkg::ST_UDP_HDR: begin
				item_d.data   = hdr_byte;
				item_d.valid  = 1'b1;
				item_d.crc_en = 1'b1;
			end
			gmii_udp_pkg::ST_LINE_NUM, gmii_udp_pkg::ST_PIXELS: begin
				// High byte of each word goes first
				item_d.data   = half ? dout[7:0] : dout[15:8];
				item_d.valid  = 1'b1;
				item_d.crc_en = 1'b1;
			end
			gmii_udp_pkg::ST_FCS: begin
				item_d.valid   = 1'b1;
				item_d.fcs     = 1'b1;
				item_d.fcs_idx = byte_cnt[1:0];
			end
			default: ;
		endcase
	end

	always_ff @(posedge fifo_clk) begin
		if (sys_rst) begin
			state    <= gmii_udp_pkg::ST_IDLE;
			byte_cnt <= '0;
			item     <= '0;
		end else begin
			item <= item_d;
			if (state == gmii_udp_pkg::ST_IDLE) begin
				byte_cnt <= '0;
				if (frame_start) begin
					state    <= gmii_udp_pkg::ST_PREAMBLE;
					byte_cnt <= 16'd1;
				end
			end else if (field_last) begin
				state    <= state_next;
				byte_cnt <= '0;
			end else begin
				byte_cnt <= byte_cnt + 16'd1;
			end
		end
	end

endmodule

/* rtl/line_gate.sv */
`timescale 1ns/10ps

module line_gate (
	input  logic fifo_clk,
	input  logic sys_rst,
	input  logic wr_en,
	input  logic empty,
	input  logic seq_idle,
	output logic frame_start,
	output logic line_pending
);

	logic                      wr_en_q;
	logic                      line_done;
	gmii_udp_pkg::line_count_t line_cnt;

	// Falling edge of wr_en closes one line
	assign line_done = wr_en_q & ~wr_en;

	assign line_pending = (line_cnt != '0);
	assign frame_start  = line_pending & seq_idle & ~empty;

	always_ff @(posedge fifo_clk) begin
		if (sys_rst) begin
			wr_en_q  <= 1'b0;
			line_cnt <= '0;
		end else begin
			wr_en_q <= wr_en;
			// Simultaneous done and start leave the count unchanged
			if (line_done && !frame_start) begin
				if (line_cnt != '1)
					line_cnt <= line_cnt + 2'd1;
			end else if (frame_start && !line_done) begin
				line_cnt <= line_cnt - 2'd1;
			end
		end
	end

endmodule

/* rtl/gmii_udp_pkg.sv */
package gmii_udp_pkg;

	// ------------------------------------------------------------
	// Vector types
	// ------------------------------------------------------------
	typedef logic [7:0]  byte_t;
	typedef logic [15:0] pixel_word_t;
	typedef logic [3:0]  station_id_t;
	typedef logic [5:0]  field_idx_t;
	typedef logic [1:0]  line_count_t;
	typedef logic [31:0] crc_t;
	typedef logic [15:0] csum_t;

	// Enum order follows the order of fields on the wire
	typedef enum logic [3:0] {
		ST_IDLE,
		ST_PREAMBLE,
		ST_SFD,
		ST_ETH_HDR,
		ST_IP_HDR,
		ST_UDP_HDR,
		ST_LINE_NUM,
		ST_PIXELS,
		ST_FCS,
		ST_GAP
	} tx_state_e;

	// One octet on its way to the GMII output stage
	typedef struct packed {
		byte_t      data;
		logic       valid;
		logic       crc_init;
		logic       crc_en;
		logic       fcs;
		logic [1:0] fcs_idx;
	} tx_item_t;

	// ------------------------------------------------------------
	// Frame constants
	// ------------------------------------------------------------
	localparam logic [47:0] DST_MAC      = 48'h00_23_45_67_89_02;
	localparam logic [47:0] SRC_MAC      = 48'h00_23_45_67_89_01;
	localparam logic [15:0] ETH_TYPE     = 16'h0800;
	localparam logic [15:0] IP_VER_TOS   = 16'h4500;
	localparam logic [15:0] IP_IDENT     = 16'h0000;
	localparam logic [15:0] IP_FLAGS     = 16'h4000;
	localparam logic [7:0]  IP_TTL       = 8'h40;
	localparam logic [7:0]  IP_PROTO     = 8'h11;
	localparam logic [31:0] SRC_IP       = {8'd192, 8'd168, 8'd0, 8'd1};
	localparam logic [31:0] DST_IP       = {8'd192, 8'd168, 8'd0, 8'd2};
	localparam logic [15:0] UDP_SRC_PORT = 16'd12344;
	localparam logic [15:0] UDP_DST_PORT = 16'd12345;

	// Payload must stay even, two bytes per FIFO word
	localparam int PIXEL_BYTES    = 64;
	localparam int LINE_NUM_BYTES = 2;
	localparam logic [15:0] UDP_LEN = 16'(8 + LINE_NUM_BYTES + PIXEL_BYTES);
	localparam logic [15:0] IP_LEN  = 16'(20) + UDP_LEN;

	localparam int PREAMBLE_BYTES = 7;
	localparam int ETH_HDR_BYTES  = 14;
	localparam int IP_HDR_BYTES   = 20;
	localparam int UDP_HDR_BYTES  = 8;
	localparam int FCS_BYTES      = 4;
	localparam int GAP_CYCLES     = 12;
	localparam int WORDS_PER_LINE = 1 + PIXEL_BYTES / 2;

	localparam byte_t PREAMBLE_BYTE = 8'h55;
	localparam byte_t SFD_BYTE      = 8'hD5;

	// Reflected CRC-32 (poly 0x04C11DB7), data bits taken LSB first
	function automatic crc_t crc32_byte(crc_t crc, byte_t data);
		crc_t c;
		c = crc;
		for (int i = 0; i < 8; i++) begin
			if (c[0] ^ data[i])
				c = (c >> 1) ^ 32'hEDB8_8320;
			else
				c = c >> 1;
		end
		return c;
	endfunction

endpackage
